// ==== Bender.yml ====
package:
  name: rv_core

export_include_dirs:
  - .

sources:
  - rv_isa_pkg.sv
  - rv_ctrl_pkg.sv
  - rv_fetch.sv
  - rv_decoder.sv
  - rv_reg_file.sv
  - rv_execute.sv
  - rv_commit.sv
  - rv_core.sv
  - target: simulation
    files:
      - tb_rv_core.sv

// ==== rv_commit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_consts.svh"

module rv_commit (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 global_en,
    input  rv_isa_pkg::word_t    pc,
    input  rv_isa_pkg::word_t    inst,
    input  rv_ctrl_pkg::decode_t dec,
    input  rv_isa_pkg::word_t    alu_res,
    input  rv_isa_pkg::word_t    rs2_val,
    input  rv_isa_pkg::word_t    dmem_rdata,
    output rv_isa_pkg::word_t    dmem_addr,
    output rv_isa_pkg::word_t    dmem_wdata,
    output logic                 dmem_we,
    output rv_isa_pkg::word_t    rf_wd,
    output rv_ctrl_pkg::commit_t rec,
    output logic                 commit
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    commit_t rec_d;

    assign dmem_addr  = alu_res;
    assign dmem_wdata = rs2_val;
    assign dmem_we    = dec.mem_we && global_en && !rst; // stores only

    always_comb begin
        case (dec.wb_sel)
            wb_mem:  rf_wd = dmem_rdata;
            wb_link: rf_wd = pc + word_t'(4);
            default: rf_wd = alu_res;
        endcase
    end

    always_comb begin
        rec_d.pc      = pc;
        rec_d.inst    = inst;
        rec_d.halt    = (inst == `RV_HALT_INST);
        rec_d.reg_we  = dec.rf_we;
        rec_d.reg_wa  = dec.rd;
        rec_d.reg_wd  = rf_wd; // value the register file takes
        rec_d.dmem_we = dec.mem_we;
        rec_d.dmem_wa = dmem_addr;
        rec_d.dmem_wd = dmem_wdata;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            commit       <= 1'b0;
            rec.halt     <= 1'b0;
            rec.reg_we   <= 1'b0;
            rec.dmem_we  <= 1'b0;
        end else if (global_en) begin
            commit <= 1'b1; // sticky once the first instruction retires
            rec    <= rec_d;
        end
    end

endmodule

`default_nettype wire

// ==== rv_core.f ====
+incdir+.
rv_isa_pkg.sv
rv_ctrl_pkg.sv
rv_fetch.sv
rv_decoder.sv
rv_reg_file.sv
rv_execute.sv
rv_commit.sv
rv_core.sv
tb_rv_core.sv

// ==== rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 global_en,
    output rv_isa_pkg::word_t    imem_raddr,
    input  rv_isa_pkg::word_t    imem_rdata,
    input  rv_isa_pkg::word_t    dmem_rdata,
    output logic                 dmem_we,
    output rv_isa_pkg::word_t    dmem_addr,
    output rv_isa_pkg::word_t    dmem_wdata,
    output logic                 commit,
    output rv_isa_pkg::word_t    commit_pc,
    output rv_isa_pkg::word_t    commit_inst,
    output logic                 commit_halt,
    output logic                 commit_reg_we,
    output rv_isa_pkg::reg_idx_t commit_reg_wa,
    output rv_isa_pkg::word_t    commit_reg_wd,
    output logic                 commit_dmem_we,
    output rv_isa_pkg::word_t    commit_dmem_wa,
    output rv_isa_pkg::word_t    commit_dmem_wd
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    word_t   pc;
    decode_t dec;
    word_t   rs1_val;
    word_t   rs2_val;
    word_t   alu_res;
    word_t   rf_wd;
    logic    rf_we;
    logic    take_branch;
    logic    jump_reg;
    commit_t rec;

    assign imem_raddr = pc;
    assign rf_we      = dec.rf_we && global_en; // no write while stalled

    rv_fetch u_fetch (
        .clk         (clk),
        .rst         (rst),
        .global_en   (global_en),
        .take_branch (take_branch),
        .jump_reg    (jump_reg),
        .target      (alu_res),
        .pc          (pc)
    );

    rv_decoder u_decoder (
        .inst (imem_rdata),
        .dec  (dec)
    );

    rv_reg_file u_reg_file (
        .clk (clk),
        .ra0 (dec.rs1),
        .ra1 (dec.rs2),
        .wa  (dec.rd),
        .we  (rf_we),
        .wd  (rf_wd),
        .rd0 (rs1_val),
        .rd1 (rs2_val)
    );

    rv_execute u_execute (
        .pc          (pc),
        .dec         (dec),
        .rs1_val     (rs1_val),
        .rs2_val     (rs2_val),
        .alu_res     (alu_res),
        .take_branch (take_branch),
        .jump_reg    (jump_reg)
    );

    rv_commit u_commit (
        .clk        (clk),
        .rst        (rst),
        .global_en  (global_en),
        .pc         (pc),
        .inst       (imem_rdata),
        .dec        (dec),
        .alu_res    (alu_res),
        .rs2_val    (rs2_val),
        .dmem_rdata (dmem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .rf_wd      (rf_wd),
        .rec        (rec),
        .commit     (commit)
    );

    assign commit_pc      = rec.pc;
    assign commit_inst    = rec.inst;
    assign commit_halt    = rec.halt;
    assign commit_reg_we  = rec.reg_we;
    assign commit_reg_wa  = rec.reg_wa;
    assign commit_reg_wd  = rec.reg_wd;
    assign commit_dmem_we = rec.dmem_we;
    assign commit_dmem_wa = rec.dmem_wa;
    assign commit_dmem_wd = rec.dmem_wd;

endmodule

`default_nettype wire

// ==== rv_core_consts.svh ====
`ifndef RV_CORE_CONSTS_SVH
`define RV_CORE_CONSTS_SVH

// data and address width
`define RV_XLEN 32

// architectural register count
`define RV_NREGS 32

// first fetch address after reset
`define RV_RESET_PC 32'h0040_0000

// ebreak word, used as the halt marker
`define RV_HALT_INST 32'h0010_0073

`endif

// ==== rv_core_patterns.txt ====
// header: program word count, expected line count; then the program image
// trace columns: pc inst reg_we reg_wa reg_wd dmem_we dmem_wa dmem_wd
1C 17
00500093 FFD00113 002081B3 40208233
001122B3 00113333 40115393 12345437
00001497 00708013 00100533 04802023
04002583 00108463 00100613 00109463
00114463 00100613 00115463 00116463
00117463 00100613 008006EF 00100613
00000797 00D78767 00100613 00100073
00400000 00500093 1 01 00000005 0 00000000 00000000
00400004 FFD00113 1 02 FFFFFFFD 0 00000000 00000000
00400008 002081B3 1 03 00000002 0 00000000 00000000
0040000C 40208233 1 04 00000008 0 00000000 00000000
00400010 001122B3 1 05 00000001 0 00000000 00000000
00400014 00113333 1 06 00000000 0 00000000 00000000
00400018 40115393 1 07 FFFFFFFE 0 00000000 00000000
0040001C 12345437 1 08 12345000 0 00000000 00000000
00400020 00001497 1 09 00401020 0 00000000 00000000
00400024 00708013 1 00 0000000C 0 00000000 00000000
00400028 00100533 1 0A 00000005 0 00000000 00000000
0040002C 04802023 0 00 00000000 1 00000040 12345000
00400030 04002583 1 0B 12345000 0 00000000 00000000
00400034 00108463 0 00 00000000 0 00000000 00000000
0040003C 00109463 0 00 00000000 0 00000000 00000000
00400040 00114463 0 00 00000000 0 00000000 00000000
00400048 00115463 0 00 00000000 0 00000000 00000000
0040004C 00116463 0 00 00000000 0 00000000 00000000
00400050 00117463 0 00 00000000 0 00000000 00000000
00400058 008006EF 1 0D 0040005C 0 00000000 00000000
00400060 00000797 1 0F 00400060 0 00000000 00000000
00400064 00D78767 1 0E 00400068 0 00000000 00000000
0040006C 00100073 0 00 00000000 0 00000000 00000000

// ==== rv_ctrl_pkg.sv ====
`default_nettype none

package rv_ctrl_pkg;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_t;

    // nine kinds need four bits
    typedef enum logic [3:0] {
        br_none, br_eq, br_ne, br_lt, br_ge,
        br_ltu, br_geu, br_jump, br_jump_reg
    } br_kind_t;

    typedef enum logic [1:0] {
        wb_alu, wb_mem, wb_link
    } wb_sel_t;

    typedef struct packed {
        rv_isa_pkg::reg_idx_t rs1;
        rv_isa_pkg::reg_idx_t rs2;
        rv_isa_pkg::reg_idx_t rd;
        rv_isa_pkg::word_t    imm;
        alu_op_t              alu_op;
        logic                 src0_is_pc;
        logic                 src1_is_imm;
        br_kind_t             br_kind;
        wb_sel_t              wb_sel;
        logic                 rf_we;
        logic                 mem_we;
    } decode_t;

    typedef struct packed {
        rv_isa_pkg::word_t    pc;
        rv_isa_pkg::word_t    inst;
        logic                 halt;
        logic                 reg_we;
        rv_isa_pkg::reg_idx_t reg_wa;
        rv_isa_pkg::word_t    reg_wd;
        logic                 dmem_we;
        rv_isa_pkg::word_t    dmem_wa;
        rv_isa_pkg::word_t    dmem_wd;
    } commit_t;

endpackage

`default_nettype wire

// ==== rv_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
    input  rv_isa_pkg::word_t    inst,
    output rv_ctrl_pkg::decode_t dec
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    opcode_t  opc;
    funct3_t  f3;
    word_t    imm_i;
    word_t    imm_s;
    word_t    imm_b;
    word_t    imm_u;
    word_t    imm_j;
    word_t    imm_sh;
    logic     shamt_form;
    alu_op_t  arith_op;
    br_kind_t branch_kind;

    assign opc = opcode_t'(inst[6:0]);
    assign f3  = inst[14:12];

    assign imm_i  = {{20{inst[31]}}, inst[31:20]};
    assign imm_s  = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b  = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u  = {inst[31:12], 12'h000};
    assign imm_j  = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_sh = {27'b0, inst[24:20]}; // slli / srli / srai
    assign shamt_form = (f3 == f3_sll) || (f3 == f3_srl_sra);

    // shared by op and op_imm where only op has sub
    always_comb begin
        case (f3)
            f3_add_sub: arith_op = (opc == opc_op && inst[30]) ? alu_sub : alu_add;
            f3_sll:     arith_op = alu_sll;
            f3_slt:     arith_op = alu_slt;
            f3_sltu:    arith_op = alu_sltu;
            f3_xor:     arith_op = alu_xor;
            f3_srl_sra: arith_op = inst[30] ? alu_sra : alu_srl;
            f3_or:      arith_op = alu_or;
            default:    arith_op = alu_and;
        endcase
    end

    always_comb begin
        case (f3)
            f3_beq:  branch_kind = br_eq;
            f3_bne:  branch_kind = br_ne;
            f3_blt:  branch_kind = br_lt;
            f3_bge:  branch_kind = br_ge;
            f3_bltu: branch_kind = br_ltu;
            f3_bgeu: branch_kind = br_geu;
            default: branch_kind = br_none;
        endcase
    end

    always_comb begin
        dec         = '0;
        dec.rs1     = inst[19:15];
        dec.rs2     = inst[24:20];
        dec.rd      = inst[11:7];
        dec.alu_op  = alu_add;
        dec.br_kind = br_none;
        dec.wb_sel  = wb_alu;
        case (opc)
            opc_op: begin
                dec.alu_op = arith_op;
                dec.rf_we  = 1'b1;
            end
            opc_op_imm: begin
                dec.alu_op      = arith_op;
                dec.src1_is_imm = 1'b1;
                dec.imm         = shamt_form ? imm_sh : imm_i;
                dec.rf_we       = 1'b1;
            end
            opc_lui: begin
                dec.rs1         = '0; // x0 + imm
                dec.src1_is_imm = 1'b1;
                dec.imm         = imm_u;
                dec.rf_we       = 1'b1;
            end
            opc_auipc: begin
                dec.src0_is_pc  = 1'b1;
                dec.src1_is_imm = 1'b1;
                dec.imm         = imm_u;
                dec.rf_we       = 1'b1;
            end
            opc_branch: begin
                dec.src0_is_pc  = 1'b1; // alu forms the target
                dec.src1_is_imm = 1'b1;
                dec.imm         = imm_b;
                dec.br_kind     = branch_kind;
            end
            opc_jal: begin
                dec.src0_is_pc  = 1'b1;
                dec.src1_is_imm = 1'b1;
                dec.imm         = imm_j;
                dec.br_kind     = br_jump;
                dec.wb_sel      = wb_link;
                dec.rf_we       = 1'b1;
            end
            opc_jalr: begin
                dec.src1_is_imm = 1'b1;
                dec.imm         = imm_i;
                dec.br_kind     = br_jump_reg;
                dec.wb_sel      = wb_link;
                dec.rf_we       = 1'b1;
            end
            opc_load: begin
                if (f3 == f3_word) begin // lw only
                    dec.src1_is_imm = 1'b1;
                    dec.imm         = imm_i;
                    dec.wb_sel      = wb_mem;
                    dec.rf_we       = 1'b1;
                end
            end
            opc_store: begin
                if (f3 == f3_word) begin // sw only
                    dec.src1_is_imm = 1'b1;
                    dec.imm         = imm_s;
                    dec.mem_we      = 1'b1;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rv_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
    input  rv_isa_pkg::word_t    pc,
    input  rv_ctrl_pkg::decode_t dec,
    input  rv_isa_pkg::word_t    rs1_val,
    input  rv_isa_pkg::word_t    rs2_val,
    output rv_isa_pkg::word_t    alu_res,
    output logic                 take_branch,
    output logic                 jump_reg
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    word_t src0;
    word_t src1;

    assign src0 = dec.src0_is_pc ? pc : rs1_val;
    assign src1 = dec.src1_is_imm ? dec.imm : rs2_val;

    always_comb begin
        case (dec.alu_op)
            alu_add:  alu_res = src0 + src1;
            alu_sub:  alu_res = src0 - src1;
            alu_sll:  alu_res = src0 << src1[4:0];
            alu_slt:  alu_res = word_t'($signed(src0) < $signed(src1));
            alu_sltu: alu_res = word_t'(src0 < src1);
            alu_xor:  alu_res = src0 ^ src1;
            alu_srl:  alu_res = src0 >> src1[4:0];
            alu_sra:  alu_res = word_t'($signed(src0) >>> src1[4:0]);
            alu_or:   alu_res = src0 | src1;
            alu_and:  alu_res = src0 & src1;
            default:  alu_res = '0;
        endcase
    end

    // compares always use the register values
    always_comb begin
        case (dec.br_kind)
            br_eq:       take_branch = (rs1_val == rs2_val);
            br_ne:       take_branch = (rs1_val != rs2_val);
            br_lt:       take_branch = ($signed(rs1_val) < $signed(rs2_val));
            br_ge:       take_branch = ($signed(rs1_val) >= $signed(rs2_val));
            br_ltu:      take_branch = (rs1_val < rs2_val);
            br_geu:      take_branch = (rs1_val >= rs2_val);
            br_jump:     take_branch = 1'b1;
            br_jump_reg: take_branch = 1'b1;
            default:     take_branch = 1'b0;
        endcase
    end

    assign jump_reg = (dec.br_kind == br_jump_reg);

endmodule

`default_nettype wire

// ==== rv_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_consts.svh"

module rv_fetch (
    input  logic              clk,
    input  logic              rst,
    input  logic              global_en,
    input  logic              take_branch,
    input  logic              jump_reg,
    input  rv_isa_pkg::word_t target,
    output rv_isa_pkg::word_t pc
);
    import rv_isa_pkg::*;

    word_t pc_q;
    word_t next_pc;

    always_comb begin
        if (!take_branch) begin
            next_pc = pc_q + word_t'(4);
        end else if (jump_reg) begin
            next_pc = target & ~word_t'(1); // jalr clears bit 0
        end else begin
            next_pc = target;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= `RV_RESET_PC;
        end else if (global_en) begin
            pc_q <= next_pc;
        end
    end

    assign pc = pc_q;

endmodule

`default_nettype wire

// ==== rv_isa_pkg.sv ====
`default_nettype none

`include "rv_core_consts.svh"

package rv_isa_pkg;

    typedef logic [4:0] reg_idx_t;
    typedef logic [2:0] funct3_t;
    typedef logic [`RV_XLEN-1:0] word_t;

    // major opcodes handled by the core
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011
    } opcode_t;

    // arithmetic funct3
    parameter funct3_t f3_add_sub = 3'b000;
    parameter funct3_t f3_sll     = 3'b001;
    parameter funct3_t f3_slt     = 3'b010;
    parameter funct3_t f3_sltu    = 3'b011;
    parameter funct3_t f3_xor     = 3'b100;
    parameter funct3_t f3_srl_sra = 3'b101;
    parameter funct3_t f3_or      = 3'b110;
    parameter funct3_t f3_and     = 3'b111;

    // branch funct3
    parameter funct3_t f3_beq  = 3'b000;
    parameter funct3_t f3_bne  = 3'b001;
    parameter funct3_t f3_blt  = 3'b100;
    parameter funct3_t f3_bge  = 3'b101;
    parameter funct3_t f3_bltu = 3'b110;
    parameter funct3_t f3_bgeu = 3'b111;

    parameter funct3_t f3_word = 3'b010; // lw / sw width

endpackage

`default_nettype wire

// ==== rv_reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_consts.svh"

module rv_reg_file (
    input  logic                 clk,
    input  rv_isa_pkg::reg_idx_t ra0,
    input  rv_isa_pkg::reg_idx_t ra1,
    input  rv_isa_pkg::reg_idx_t wa,
    input  logic                 we,
    input  rv_isa_pkg::word_t    wd,
    output rv_isa_pkg::word_t    rd0,
    output rv_isa_pkg::word_t    rd1
);
    import rv_isa_pkg::*;

    word_t regs [`RV_NREGS] = '{default: '0}; // all registers start at zero

    always_ff @(posedge clk) begin
        if (we && wa != '0) begin // x0 stays zero
            regs[wa] <= wd;
        end
    end

    assign rd0 = regs[ra0];
    assign rd1 = regs[ra1];

endmodule

`default_nettype wire

// ==== tb_rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_consts.svh"

module tb_rv_core;
    import rv_isa_pkg::*;

    localparam int PERIOD    = 100;
    localparam int RST_CYC   = 8;
    localparam int IMEM_SIZE = 256;

    logic     clk = 1'b0;
    logic     rst;
    logic     global_en;
    word_t    imem_raddr;
    word_t    imem_rdata;
    word_t    dmem_rdata;
    logic     dmem_we;
    word_t    dmem_addr;
    word_t    dmem_wdata;
    logic     commit;
    word_t    commit_pc;
    word_t    commit_inst;
    logic     commit_halt;
    logic     commit_reg_we;
    reg_idx_t commit_reg_wa;
    word_t    commit_reg_wd;
    logic     commit_dmem_we;
    word_t    commit_dmem_wa;
    word_t    commit_dmem_wd;

    word_t pat [0:511]; // counts, program image, expected trace
    word_t imem [0:IMEM_SIZE-1];
    word_t dmem [0:255];
    word_t imem_idx;

    int    n_prog;
    int    n_exp;
    int    exp_idx;
    int    mismatches;
    int    other_errs;
    logic  captured;
    logic  done;
    logic  loaded;
    word_t last_pc;

    rv_core DUT (
        .clk            (clk),
        .rst            (rst),
        .global_en      (global_en),
        .imem_raddr     (imem_raddr),
        .imem_rdata     (imem_rdata),
        .dmem_rdata     (dmem_rdata),
        .dmem_we        (dmem_we),
        .dmem_addr      (dmem_addr),
        .dmem_wdata     (dmem_wdata),
        .commit         (commit),
        .commit_pc      (commit_pc),
        .commit_inst    (commit_inst),
        .commit_halt    (commit_halt),
        .commit_reg_we  (commit_reg_we),
        .commit_reg_wa  (commit_reg_wa),
        .commit_reg_wd  (commit_reg_wd),
        .commit_dmem_we (commit_dmem_we),
        .commit_dmem_wa (commit_dmem_wa),
        .commit_dmem_wd (commit_dmem_wd)
    );

    always #(PERIOD / 2) clk = ~clk;

    // asynchronous instruction and data memories
    assign imem_idx   = (imem_raddr - `RV_RESET_PC) >> 2;
    assign imem_rdata = (imem_idx < IMEM_SIZE) ? imem[imem_idx[7:0]] : '0;
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    always @(posedge clk) begin
        if (dmem_we) begin
            dmem[dmem_addr[9:2]] <= dmem_wdata;
        end
    end

    task automatic compare_field(input string name, input word_t exp, input word_t act);
        assert (exp == act) else begin
            mismatches++;
            $display("Mismatch %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_record();
        int base;
        if (exp_idx >= n_exp) begin
            other_errs++;
            $display("a commit appeared after the last expected trace line");
            done = 1'b1;
        end else begin
            base = 2 + n_prog + 8 * exp_idx;
            compare_field("commit_pc", pat[base], commit_pc);
            compare_field("commit_inst", pat[base + 1], commit_inst);
            compare_field("commit_reg_we", pat[base + 2], word_t'(commit_reg_we));
            if (pat[base + 2] != '0) begin // rd fields only matter on a write
                compare_field("commit_reg_wa", pat[base + 3], word_t'(commit_reg_wa));
                compare_field("commit_reg_wd", pat[base + 4], commit_reg_wd);
            end
            compare_field("commit_dmem_we", pat[base + 5], word_t'(commit_dmem_we));
            if (pat[base + 5] != '0) begin
                compare_field("commit_dmem_wa", pat[base + 6], commit_dmem_wa);
                compare_field("commit_dmem_wd", pat[base + 7], commit_dmem_wd);
            end
            compare_field("commit_halt", word_t'(pat[base + 1] == `RV_HALT_INST),
                          word_t'(commit_halt));
            last_pc = commit_pc;
            exp_idx++;
            if (commit_halt) begin
                assert (exp_idx == n_exp) else begin
                    other_errs++;
                    $display("halt committed before the end of the expected trace");
                end
                done = 1'b1;
            end
        end
    endtask

    // the instruction in flight is the next expected trace line
    task automatic verify_dmem_request();
        int   base;
        logic exp_we;
        base   = 2 + n_prog + 8 * exp_idx;
        exp_we = global_en && (pat[base + 5] != '0);
        compare_field("dmem_we", word_t'(exp_we), word_t'(dmem_we));
        if (exp_we) begin
            compare_field("dmem_addr", pat[base + 6], dmem_addr);
            compare_field("dmem_wdata", pat[base + 7], dmem_wdata);
        end
    endtask

    // the DUT takes a record at every edge where it saw global_en high
    always @(posedge clk) begin
        captured <= !rst && global_en;
    end

    always @(negedge clk) begin
        if (!rst && !done && loaded) begin
            if (captured) begin
                assert (commit) else begin
                    other_errs++;
                    $display("commit stayed low after an enabled cycle");
                end
                if (commit) begin
                    check_record();
                end
            end else if (commit) begin
                // record holds while stalled
                compare_field("commit_pc", last_pc, commit_pc);
            end
            if (!done && exp_idx < n_exp) begin
                verify_dmem_request();
            end
        end
    end

    initial begin
        int seed;
        int gap;
        rst        = 1'b1;
        global_en  = 1'b0;
        captured   = 1'b0;
        done       = 1'b0;
        loaded     = 1'b0;
        mismatches = 0;
        other_errs = 0;
        exp_idx    = 0;
        gap        = 0;
        last_pc    = '0;
        seed       = $urandom(7);
        for (int i = 0; i < IMEM_SIZE; i++) begin
            imem[i] = '0;
            dmem[i] = 32'hDA7A_0000 ^ (word_t'(i) << 2);
        end
        $readmemh("rv_core_patterns.txt", pat);
        n_prog = pat[0];
        n_exp  = pat[1];
        for (int i = 0; i < n_prog; i++) begin
            imem[i] = pat[2 + i];
        end
        loaded = 1'b1;

        repeat (RST_CYC) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!commit) else begin
            other_errs++;
            $display("commit is high right after reset");
        end
        compare_field("imem_raddr", `RV_RESET_PC, imem_raddr);

        while (!done) begin
            @(posedge clk);
            if (gap > 0) begin
                global_en <= 1'b0;
                gap--;
            end else if ($urandom_range(5, 0) == 0) begin
                global_en <= 1'b0; // stall stretch of 1 to 3 cycles
                gap = $urandom_range(2, 0);
            end else begin
                global_en <= 1'b1;
            end
        end

        $display("errors: %0d mismatches, %0d other failures", mismatches, other_errs);
        if (mismatches + other_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        int limit;
        wait (loaded);
        limit = (RST_CYC + 20 * n_exp) * PERIOD;
        #(limit);
        other_errs++;
        $display("timeout: the program did not reach the halt instruction");
        $display("errors: %0d mismatches, %0d other failures", mismatches, other_errs);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire
